/* sparse_feed_defines.svh */
`ifndef SPARSE_FEED_DEFINES_SVH
`define SPARSE_FEED_DEFINES_SVH

// row widths in bits
`define SF_K_WIDTH      512
`define SF_Q_WIDTH      256

// external memory address
`define SF_ADDR_WIDTH   12

// K matrix geometry
`define SF_K_ROWS       1024
`define SF_BLOCK_ROWS   64
`define SF_BLOCKS       16

// two halves of 64 rows each
`define SF_Q_BUF_ROWS   128

// region prefixes in front of the row index
`define SF_REGION_K     2'b10
`define SF_REGION_Q     1'b0

`endif

/* sparse_feed_pkg.sv */
`default_nettype none

`include "sparse_feed_defines.svh"

package sparse_feed_pkg;

    typedef logic [`SF_K_WIDTH-1:0]    k_row_t;
    typedef logic [`SF_Q_WIDTH-1:0]    q_row_t;
    typedef logic [`SF_ADDR_WIDTH-1:0] mem_addr_t;

    typedef enum logic {
        K_LOADING,
        K_DONE
    } k_load_state_e;

    // low and high fill target one half each
    typedef enum logic [1:0] {
        Q_INIT,
        Q_WAIT,
        Q_FILL_LOW,
        Q_FILL_HIGH
    } q_stage_state_e;

    typedef enum logic {
        SP_IDLE,
        SP_STREAM
    } sp_state_e;

endpackage

`default_nettype wire

/* row_buffer.sv */
`default_nettype none

module row_buffer #(
    parameter int DEPTH = 128,
    parameter int WIDTH = 256
) (
    input  logic                     clk,
    input  logic                     i_wr_en,
    input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
    input  logic [WIDTH-1:0]         i_wr_data,
    input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
    output logic [WIDTH-1:0]         o_rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read port, one cycle latency
    // same-address read and write returns the old row
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

/* k_loader.sv */
`default_nettype none

`include "sparse_feed_defines.svh"

module k_loader (
    input  logic                          clk,
    input  logic                          rst_n,
    output sparse_feed_pkg::mem_addr_t    o_mem_a_addr,
    output logic                          o_k_wr_en,
    output logic [$clog2(`SF_K_ROWS)-1:0] o_k_wr_addr,
    output logic                          o_k_loaded
);
    import sparse_feed_pkg::*;

    localparam int               IDX_W    = $clog2(`SF_K_ROWS);
    localparam logic [IDX_W-1:0] LAST_ROW = IDX_W'(`SF_K_ROWS - 1);

    k_load_state_e    state;
    logic [IDX_W-1:0] row_cnt;

    assign o_mem_a_addr = {`SF_REGION_K, row_cnt};

    // one address per cycle until the last row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= K_LOADING;
            row_cnt <= '0;
        end else if (state == K_LOADING) begin
            row_cnt <= row_cnt + 1'b1;
            if (row_cnt == LAST_ROW) begin
                state <= K_DONE;
            end
        end
    end

    // port A data arrives a cycle after its address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_k_wr_en  <= 1'b0;
            o_k_loaded <= 1'b0;
        end else begin
            o_k_wr_en <= (state == K_LOADING);
            // loaded once the final write has gone in
            if (state == K_DONE && o_k_wr_en) begin
                o_k_loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_k_wr_addr <= row_cnt;
    end

    // a write seen in K_DONE can only be the last row
    a_no_write_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        (state == K_DONE && o_k_wr_en) |-> (o_k_wr_addr == LAST_ROW));

endmodule

`default_nettype wire

/* q_stager.sv */
`default_nettype none

`include "sparse_feed_defines.svh"

module q_stager (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_sp_gen_over,
    output sparse_feed_pkg::mem_addr_t        o_mem_b_addr,
    output logic                              o_q_wr_en,
    output logic [$clog2(`SF_Q_BUF_ROWS)-1:0] o_q_wr_addr
);
    import sparse_feed_pkg::*;

    localparam int SLOT_W = $clog2(`SF_Q_BUF_ROWS);
    localparam int HALF_W = SLOT_W - 1;
    localparam int QIDX_W = `SF_ADDR_WIDTH - $bits(`SF_REGION_Q);

    q_stage_state_e    state;
    logic [QIDX_W-1:0] q_idx;
    logic [SLOT_W-1:0] slot_cnt;
    logic              next_high;
    logic              half_end;

    assign o_mem_b_addr = {`SF_REGION_Q, q_idx};

    // last slot of whichever half is filling
    assign half_end = (slot_cnt[HALF_W-1:0] == '1);

    ////////////////////////////////////////////////////////////
    // fill sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= Q_INIT;
            q_idx     <= '0;
            slot_cnt  <= '0;
            next_high <= 1'b0;
        end else begin
            case (state)
                Q_INIT: begin
                    q_idx    <= q_idx + 1'b1;
                    slot_cnt <= slot_cnt + 1'b1;
                    if (slot_cnt == '1) begin
                        state <= Q_WAIT;
                    end
                end
                Q_WAIT: begin
                    // each refill goes to the other half
                    if (i_sp_gen_over) begin
                        state     <= next_high ? Q_FILL_HIGH : Q_FILL_LOW;
                        slot_cnt  <= {next_high, {HALF_W{1'b0}}};
                        next_high <= ~next_high;
                    end
                end
                Q_FILL_LOW, Q_FILL_HIGH: begin
                    q_idx    <= q_idx + 1'b1;
                    slot_cnt <= slot_cnt + 1'b1;
                    if (half_end) begin
                        state <= Q_WAIT;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // buffer writes, one cycle behind the port B address
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_q_wr_en <= 1'b0;
        end else begin
            o_q_wr_en <= (state != Q_WAIT);
        end
    end

    always_ff @(posedge clk) begin
        o_q_wr_addr <= slot_cnt;
    end

    // generator pulse during a fill is dropped
    a_gen_over_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        i_sp_gen_over |-> (state == Q_WAIT))
        else $warning("q_stager: sp_gen_over during a Q fill, refill request lost");

endmodule

`default_nettype wire

/* sparse_streamer.sv */
`default_nettype none

`include "sparse_feed_defines.svh"

module sparse_streamer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_k_loaded,
    input  logic                              i_cu_over_last,
    output logic [$clog2(`SF_K_ROWS)-1:0]     o_k_rd_addr,
    output logic [$clog2(`SF_Q_BUF_ROWS)-1:0] o_q_rd_addr,
    output logic                              o_sp_valid,
    output logic                              o_sp_last
);
    import sparse_feed_pkg::*;

    localparam int ROW_W = $clog2(`SF_BLOCK_ROWS);
    localparam int BLK_W = $clog2(`SF_BLOCKS);
    localparam int BEAT_W = $clog2(`SF_K_ROWS);

    sp_state_e         state;
    logic              k_loaded_q;
    logic              start;
    logic              last_beat;
    logic [BLK_W-1:0]  blk_cnt;
    logic [ROW_W-1:0]  row_cnt;
    logic              half;
    logic [BEAT_W-1:0] beat_cnt;

    // first pass on the K load edge, later ones on cu_over_last
    assign start     = (i_k_loaded && !k_loaded_q) || i_cu_over_last;
    assign last_beat = (blk_cnt == BLK_W'(`SF_BLOCKS - 1)) &&
                       (row_cnt == ROW_W'(`SF_BLOCK_ROWS - 1));

    // K walks all blocks, Q repeats its half per block
    assign o_k_rd_addr = {blk_cnt, row_cnt};
    assign o_q_rd_addr = {half, row_cnt};

    ////////////////////////////////////////////////////////////
    // pass sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SP_IDLE;
            k_loaded_q <= 1'b0;
            blk_cnt    <= '0;
            row_cnt    <= '0;
            half       <= 1'b0;
        end else begin
            k_loaded_q <= i_k_loaded;
            case (state)
                SP_IDLE: begin
                    if (start) begin
                        state <= SP_STREAM;
                    end
                end
                SP_STREAM: begin
                    // counters wrap back to zero on the last beat
                    row_cnt <= row_cnt + 1'b1;
                    if (row_cnt == '1) begin
                        blk_cnt <= blk_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= SP_IDLE;
                        half  <= ~half;
                    end
                end
            endcase
        end
    end

    // flags trail the reads by the buffer latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_sp_valid <= 1'b0;
            o_sp_last  <= 1'b0;
        end else begin
            o_sp_valid <= (state == SP_STREAM);
            o_sp_last  <= (state == SP_STREAM) && last_beat;
        end
    end

    // valid beats counted apart from the read counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (o_sp_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // last flag only with valid and only on the final beat of a pass
    a_last_ends_pass: assert property (@(posedge clk) disable iff (!rst_n)
        (o_sp_valid || o_sp_last) |-> (o_sp_valid && (o_sp_last == (beat_cnt == '1))));

endmodule

`default_nettype wire

/* sparse_feed_top.sv */
`default_nettype none

`include "sparse_feed_defines.svh"

module sparse_feed_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  sparse_feed_pkg::k_row_t    i_mem_a_data,
    input  sparse_feed_pkg::k_row_t    i_mem_b_data,
    input  logic                       i_sp_gen_over,
    input  logic                       i_cu_over_last,
    output sparse_feed_pkg::mem_addr_t o_mem_a_addr,
    output sparse_feed_pkg::mem_addr_t o_mem_b_addr,
    output logic                       o_k_loaded,
    output logic                       o_sp_valid,
    output logic                       o_sp_last,
    output sparse_feed_pkg::k_row_t    o_sp_k_data,
    output sparse_feed_pkg::q_row_t    o_sp_q_data
);

    localparam int K_AW = $clog2(`SF_K_ROWS);
    localparam int Q_AW = $clog2(`SF_Q_BUF_ROWS);

    logic            k_wr_en;
    logic [K_AW-1:0] k_wr_addr;
    logic [K_AW-1:0] k_rd_addr;
    logic            q_wr_en;
    logic [Q_AW-1:0] q_wr_addr;
    logic [Q_AW-1:0] q_rd_addr;

    ////////////////////////////////////////////////////////////
    // controllers
    ////////////////////////////////////////////////////////////

    k_loader k_loader_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_mem_a_addr (o_mem_a_addr),
        .o_k_wr_en    (k_wr_en),
        .o_k_wr_addr  (k_wr_addr),
        .o_k_loaded   (o_k_loaded)
    );

    q_stager q_stager_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_sp_gen_over (i_sp_gen_over),
        .o_mem_b_addr  (o_mem_b_addr),
        .o_q_wr_en     (q_wr_en),
        .o_q_wr_addr   (q_wr_addr)
    );

    sparse_streamer sparse_streamer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_k_loaded     (o_k_loaded),
        .i_cu_over_last (i_cu_over_last),
        .o_k_rd_addr    (k_rd_addr),
        .o_q_rd_addr    (q_rd_addr),
        .o_sp_valid     (o_sp_valid),
        .o_sp_last      (o_sp_last)
    );

    ////////////////////////////////////////////////////////////
    // buffers
    ////////////////////////////////////////////////////////////

    row_buffer #(.DEPTH(`SF_K_ROWS), .WIDTH(`SF_K_WIDTH)) k_buf_i (
        .clk       (clk),
        .i_wr_en   (k_wr_en),
        .i_wr_addr (k_wr_addr),
        .i_wr_data (i_mem_a_data),
        .i_rd_addr (k_rd_addr),
        .o_rd_data (o_sp_k_data)
    );

    // only the low half of port B carries the Q row
    row_buffer #(.DEPTH(`SF_Q_BUF_ROWS), .WIDTH(`SF_Q_WIDTH)) q_buf_i (
        .clk       (clk),
        .i_wr_en   (q_wr_en),
        .i_wr_addr (q_wr_addr),
        .i_wr_data (i_mem_b_data[`SF_Q_WIDTH-1:0]),
        .i_rd_addr (q_rd_addr),
        .o_rd_data (o_sp_q_data)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after an edge, clear of the DUT sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_sparse_feed.sv */
`default_nettype none

`include "sparse_feed_defines.svh"

module tb_sparse_feed;
    timeunit 1ns;
    timeprecision 1ps;
    import sparse_feed_pkg::*;

    localparam int          K_ROWS       = `SF_K_ROWS;
    localparam int          BLOCK_ROWS   = `SF_BLOCK_ROWS;
    localparam int          Q_BUF_ROWS   = `SF_Q_BUF_ROWS;
    localparam int          LAST_BEAT    = K_ROWS - 1;
    localparam int          K_IDX_W      = $clog2(K_ROWS);
    localparam int          Q_IDX_W      = `SF_ADDR_WIDTH - 1;
    localparam int          K_LANES      = `SF_K_WIDTH / 16;
    localparam int          Q_LANES      = `SF_Q_WIDTH / 16;
    localparam logic [15:0] SEED_WORD    = 16'h3c5a;
    localparam int          PASS_TIMEOUT = 2000;
    localparam int          REFILL_WAIT  = BLOCK_ROWS + 4;
    localparam int          PASSES       = 5;

    logic      clk;
    logic      rst_n;
    k_row_t    mem_a_data;
    k_row_t    mem_b_data;
    logic      sp_gen_over;
    logic      cu_over_last;
    mem_addr_t mem_a_addr;
    mem_addr_t mem_b_addr;
    logic      k_loaded;
    logic      sp_valid;
    logic      sp_last;
    k_row_t    sp_k_data;
    q_row_t    sp_q_data;

    // shadow of the Q index held in each buffer slot
    int        slot_q_idx [Q_BUF_ROWS];
    int        next_q_idx;
    int        refill_half;
    int        passes_done;
    int        beat_idx;
    int        stream_errors;
    int        seq_errors;
    int        timeouts;
    mem_addr_t a_addr_prev;
    mem_addr_t b_addr_prev;
    k_row_t    exp_k;
    q_row_t    exp_q;

    tb_clock_gen clock_gen_i (.clk(clk), .rst_n(rst_n));

    sparse_feed_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_mem_a_data   (mem_a_data),
        .i_mem_b_data   (mem_b_data),
        .i_sp_gen_over  (sp_gen_over),
        .i_cu_over_last (cu_over_last),
        .o_mem_a_addr   (mem_a_addr),
        .o_mem_b_addr   (mem_b_addr),
        .o_k_loaded     (k_loaded),
        .o_sp_valid     (sp_valid),
        .o_sp_last      (sp_last),
        .o_sp_k_data    (sp_k_data),
        .o_sp_q_data    (sp_q_data)
    );

    ////////////////////////////////////////////////////////////
    // data rule and reference
    ////////////////////////////////////////////////////////////

    function automatic k_row_t k_row_rule(input int i);
        k_row_t r;
        for (int l = 0; l < K_LANES; l++) begin
            r[l*16 +: 16] = 16'(i * 32 + l) ^ SEED_WORD;
        end
        return r;
    endfunction

    function automatic q_row_t q_row_rule(input int j);
        q_row_t r;
        for (int l = 0; l < Q_LANES; l++) begin
            r[l*16 +: 16] = 16'(j * 16 + l) ^ SEED_WORD;
        end
        return r;
    endfunction

    function automatic k_row_t port_b_row(input mem_addr_t a);
        q_row_t q;
        q = q_row_rule(int'(a[Q_IDX_W-1:0]));
        // upper half is junk the stager must drop
        return {~q, q};
    endfunction

    // even passes read the low half, odd passes the high half
    function automatic void expected_beat(input int pass, input int beat,
                                          output k_row_t k, output q_row_t q);
        int slot;
        slot = (pass % 2) * BLOCK_ROWS + beat % BLOCK_ROWS;
        k = k_row_rule(beat);
        q = q_row_rule(slot_q_idx[slot]);
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_k_row(input string name, input k_row_t exp, input k_row_t act,
                               inout int errors);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_q_row(input string name, input q_row_t exp, input q_row_t act,
                               inout int errors);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act,
                              inout int errors);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act,
                              inout int errors);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act,
                               inout int errors);
        if (act != exp) begin
            errors++;
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory model and stream monitor
    ////////////////////////////////////////////////////////////

    // each port answers the address seen one cycle earlier
    initial begin : memory_model
        mem_a_data  = '0;
        mem_b_data  = '0;
        a_addr_prev = '0;
        b_addr_prev = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_a_data  = k_row_rule(int'(a_addr_prev[K_IDX_W-1:0]));
            mem_b_data  = port_b_row(b_addr_prev);
            a_addr_prev = mem_a_addr;
            b_addr_prev = mem_b_addr;
        end
    end

    initial begin : stream_monitor
        passes_done   = 0;
        beat_idx      = 0;
        stream_errors = 0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && sp_valid === 1'b1) begin
                expected_beat(passes_done, beat_idx, exp_k, exp_q);
                check_k_row($sformatf("pass %0d beat %0d K row", passes_done, beat_idx),
                            exp_k, sp_k_data, stream_errors);
                check_q_row($sformatf("pass %0d beat %0d Q row", passes_done, beat_idx),
                            exp_q, sp_q_data, stream_errors);
                check_flag($sformatf("pass %0d beat %0d last", passes_done, beat_idx),
                           beat_idx == LAST_BEAT, sp_last, stream_errors);
                if (beat_idx == LAST_BEAT) begin
                    beat_idx = 0;
                    passes_done++;
                end else begin
                    beat_idx++;
                end
            end else if (beat_idx != 0) begin
                stream_errors++;
                $display("o_sp_valid dropped in pass %0d after %0d beats",
                         passes_done, beat_idx);
                beat_idx = 0;
                passes_done++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_passes(input int target, output bit ok);
        int cycles;
        cycles = 0;
        while (passes_done < target && cycles < PASS_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        ok = (passes_done >= target);
        if (!ok) begin
            timeouts++;
            $display("timeout: pass %0d did not finish within %0d cycles",
                     target - 1, PASS_TIMEOUT);
        end
    endtask

    // the next refill covers the other half with the next 64 Q rows
    task automatic send_gen_over();
        for (int s = 0; s < BLOCK_ROWS; s++) begin
            slot_q_idx[refill_half * BLOCK_ROWS + s] = next_q_idx;
            next_q_idx++;
        end
        refill_half = 1 - refill_half;
        sp_gen_over = 1'b1;
        step_cycle();
        sp_gen_over = 1'b0;
    endtask

    task automatic send_cu_over_last();
        cu_over_last = 1'b1;
        step_cycle();
        cu_over_last = 1'b0;
    endtask

    // valid must appear exactly two cycles after the pulse
    task automatic start_pass(input string name);
        send_cu_over_last();
        check_flag({name, " start gap"}, 1'b0, sp_valid, seq_errors);
        step_cycle();
        check_flag({name, " start"}, 1'b1, sp_valid, seq_errors);
    endtask

    // port B rests on the next unfetched Q row between fills
    task automatic check_idle(input string name, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            step_cycle();
            check_flag(name, 1'b0, sp_valid, seq_errors);
            check_addr({name, " Q address"}, {`SF_REGION_Q, Q_IDX_W'(next_q_idx)},
                       mem_b_addr, seq_errors);
        end
    endtask

    task automatic run_tests();
        bit ok;
        int n;
        int gap;
        n = 0;
        while (rst_n !== 1'b1 && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
            return;
        end
        // K load walks the K region one row per cycle, Q fill walks 0 to 127
        n = 0;
        while (k_loaded !== 1'b1 && n < K_ROWS + 64) begin
            if (n < K_ROWS) begin
                check_addr($sformatf("K load address %0d", n),
                           {`SF_REGION_K, K_IDX_W'(n)}, mem_a_addr, seq_errors);
            end
            if (n < Q_BUF_ROWS) begin
                check_addr($sformatf("Q fill address %0d", n),
                           {`SF_REGION_Q, Q_IDX_W'(n)}, mem_b_addr, seq_errors);
            end
            @(negedge clk);
            n++;
        end
        if (k_loaded !== 1'b1) begin
            timeouts++;
            $display("timeout: o_k_loaded never rose");
            return;
        end
        check_count("K load length", K_ROWS + 1, n, seq_errors);
        @(negedge clk);
        check_flag("first pass start gap", 1'b0, sp_valid, seq_errors);
        @(negedge clk);
        check_flag("first pass start", 1'b1, sp_valid, seq_errors);
        wait_passes(1, ok);
        if (!ok) begin
            return;
        end
        // second pass with a stray request in mid-pass
        gap = 4 + int'($urandom % 32'd16);
        repeat (gap) step_cycle();
        start_pass("pass 1");
        gap = 200 + int'($urandom % 32'd500);
        repeat (gap) step_cycle();
        send_cu_over_last();
        wait_passes(2, ok);
        if (!ok) begin
            return;
        end
        check_idle("idle after pass 1", 40);
        // refills alternate low, high, low
        for (int p = 2; p < PASSES; p++) begin
            send_gen_over();
            gap = REFILL_WAIT + int'($urandom % 32'd24);
            repeat (gap) step_cycle();
            start_pass($sformatf("pass %0d", p));
            wait_passes(p + 1, ok);
            if (!ok) begin
                return;
            end
        end
        check_idle("idle after last pass", 40);
        check_count("pass count", PASSES, passes_done, seq_errors);
    endtask

    initial begin : main_sequence
        sp_gen_over  = 1'b0;
        cu_over_last = 1'b0;
        seq_errors   = 0;
        timeouts     = 0;
        for (int s = 0; s < Q_BUF_ROWS; s++) begin
            slot_q_idx[s] = s;
        end
        next_q_idx  = Q_BUF_ROWS;
        refill_half = 0;
        void'($urandom(32'hd7d3));
        run_tests();
        $display("errors: %0d stream, %0d sequence, %0d timeouts",
                 stream_errors, seq_errors, timeouts);
        if (stream_errors == 0 && seq_errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sparse_feed.f */
+incdir+.
sparse_feed_pkg.sv
row_buffer.sv
k_loader.sv
q_stager.sv
sparse_streamer.sv
sparse_feed_top.sv
tb_clock_gen.sv
tb_sparse_feed.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sparse_feed testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sparse_feed.f --top-module tb_sparse_feed -o tb_sparse_feed
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sparse_feed > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
exit 1
